/* src.f */
+incdir+src
+incdir+tb
src/rv_isa_pkg.sv
src/core_ctrl_pkg.sv
src/inst_mem.sv
src/inst_decoder.sv
src/reg_file.sv
src/exec_unit.sv
src/data_mem.sv
src/rv_core.sv
tb/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_rv_core
FILELIST  := src.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard src/*.sv src/*.svh tb/*.sv tb/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qF -- '*** PASSED ***' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Columns: byte offset from the reset pc, instruction word, expected rd_we, rd, rd value.
// Rows given to place_word sit in a skipped path and never retire.
    task automatic build_program();
        // ALU with negative operands.
        add_row(8'h10, i_word(op_imm, 3'd0, 5'd1, 5'd0, 12'hffb), 1'b1, 5'd1, 32'hffff_fffb);
        add_row(8'h14, i_word(op_imm, 3'd0, 5'd2, 5'd0, 12'h003), 1'b1, 5'd2, 32'h0000_0003);
        add_row(8'h18, r_word(7'h20, 3'd0, 5'd3, 5'd2, 5'd1), 1'b1, 5'd3, 32'h0000_0008);
        add_row(8'h1c, r_word(7'h20, 3'd5, 5'd4, 5'd1, 5'd2), 1'b1, 5'd4, 32'hffff_ffff);
        add_row(8'h20, r_word(7'h00, 3'd2, 5'd5, 5'd1, 5'd2), 1'b1, 5'd5, 32'h0000_0001);
        add_row(8'h24, r_word(7'h00, 3'd3, 5'd6, 5'd1, 5'd2), 1'b1, 5'd6, 32'h0000_0000);
        add_row(8'h28, i_word(op_imm, 3'd5, 5'd7, 5'd1, 12'h004), 1'b1, 5'd7, 32'h0fff_ffff);
        add_row(8'h2c, i_word(op_imm, 3'd4, 5'd8, 5'd1, 12'h0f0), 1'b1, 5'd8, 32'hffff_ff0b);
        add_row(8'h30, u_word(op_lui, 5'd9, 20'h12345), 1'b1, 5'd9, 32'h1234_5000);
        add_row(8'h34, i_word(op_imm, 3'd0, 5'd9, 5'd9, 12'h678), 1'b1, 5'd9, 32'h1234_5678);
        add_row(8'h38, u_word(op_auipc, 5'd10, 20'h00001), 1'b1, 5'd10, 32'h8000_1038);
        // Word at byte address 0x100, then one byte and one halfword patched into it.
        add_row(8'h3c, s_word(3'd2, 5'd0, 5'd9, 12'h100), 1'b0, 5'd0, 32'h0);
        add_row(8'h40, s_word(3'd0, 5'd0, 5'd1, 12'h101), 1'b0, 5'd0, 32'h0);
        add_row(8'h44, i_word(op_load, 3'd2, 5'd11, 5'd0, 12'h100), 1'b1, 5'd11, 32'h1234_fb78);
        add_row(8'h48, i_word(op_load, 3'd0, 5'd12, 5'd0, 12'h101), 1'b1, 5'd12, 32'hffff_fffb);
        add_row(8'h4c, i_word(op_load, 3'd4, 5'd13, 5'd0, 12'h101), 1'b1, 5'd13, 32'h0000_00fb);
        add_row(8'h50, i_word(op_load, 3'd1, 5'd14, 5'd0, 12'h100), 1'b1, 5'd14, 32'hffff_fb78);
        add_row(8'h54, i_word(op_load, 3'd5, 5'd15, 5'd0, 12'h100), 1'b1, 5'd15, 32'h0000_fb78);
        add_row(8'h58, s_word(3'd1, 5'd0, 5'd2, 12'h102), 1'b0, 5'd0, 32'h0);
        add_row(8'h5c, i_word(op_load, 3'd1, 5'd16, 5'd0, 12'h102), 1'b1, 5'd16, 32'h0000_0003);
        // Branches on x1 = -5 and x2 = 3.
        add_row(8'h60, b_word(3'd0, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'h0);
        add_row(8'h64, b_word(3'd1, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'h0);
        place_word(8'h68, i_word(op_imm, 3'd0, 5'd17, 5'd0, 12'h001));
        add_row(8'h6c, b_word(3'd4, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'h0);
        place_word(8'h70, i_word(op_imm, 3'd0, 5'd17, 5'd0, 12'h002));
        add_row(8'h74, b_word(3'd6, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'h0);
        add_row(8'h78, b_word(3'd7, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'h0);
        place_word(8'h7c, i_word(op_imm, 3'd0, 5'd17, 5'd0, 12'h003));
        add_row(8'h80, b_word(3'd5, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'h0);
        // Jal over two words, then jalr to an odd target.
        add_row(8'h84, j_word(5'd18, 21'd12), 1'b1, 5'd18, 32'h8000_0088);
        place_word(8'h88, i_word(op_imm, 3'd0, 5'd17, 5'd0, 12'h004));
        place_word(8'h8c, i_word(op_imm, 3'd0, 5'd17, 5'd0, 12'h005));
        add_row(8'h90, u_word(op_auipc, 5'd19, 20'h00000), 1'b1, 5'd19, 32'h8000_0090);
        add_row(8'h94, i_word(op_jalr, 3'd0, 5'd20, 5'd19, 12'h011), 1'b1, 5'd20, 32'h8000_0098);
        place_word(8'h98, i_word(op_imm, 3'd0, 5'd17, 5'd0, 12'h006));
        place_word(8'h9c, i_word(op_imm, 3'd0, 5'd17, 5'd0, 12'h007));
        add_row(8'ha0, i_word(op_imm, 3'd0, 5'd0, 5'd0, 12'h007), 1'b1, 5'd0, 32'h0000_0007);
        add_row(8'ha4, r_word(7'h00, 3'd0, 5'd21, 5'd0, 5'd2), 1'b1, 5'd21, 32'h0000_0003);
        // Ebreak.
        add_row(8'ha8, 32'h0010_0073, 1'b0, 5'd0, 32'h0);
    endtask

`endif

/* tb/tb_rv_core.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_rv_core;

    localparam int addr_w      = $clog2(`CORE_IMEM_WORDS);
    localparam int clk_period  = 8;
    localparam int reset_hold  = 8;
    localparam int head_words  = 4;
    localparam int halt_checks = 4;

    // Major opcodes from the RV32I encoding tables.
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_jalr  = 7'b1100111;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;

    logic                   clk;
    logic                   rst_n;
    logic                   prog_we;
    logic [addr_w-1:0]      prog_addr;
    logic [31:0]            prog_data;
    logic [`CORE_XLEN-1:0]  pc;
    logic [`CORE_XLEN-1:0]  snpc;
    logic [`CORE_XLEN-1:0]  dnpc;
    core_ctrl_pkg::retire_t retire;
    logic                   retire_valid;
    logic                   halted;

    logic [31:0]            image [`CORE_IMEM_WORDS];
    int                     image_len;
    core_ctrl_pkg::retire_t expected [$];
    logic                   table_ready;
    int                     watchdog_cycles;

    rv_core u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .pc           (pc),
        .snpc         (snpc),
        .dnpc         (dnpc),
        .retire       (retire),
        .retire_valid (retire_valid),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] i_word(input logic [6:0] op, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] s_word(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_word(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic string retire_text(input core_ctrl_pkg::retire_t r);
        return $sformatf("pc %h we %b rd %0d value %h", r.pc, r.rd_we, r.rd, r.rd_value);
    endfunction

    task automatic place_word(input int unsigned off, input logic [31:0] word);
        image[off / 4] = word;
        if (off / 4 + 1 > image_len) begin
            image_len = off / 4 + 1;
        end
    endtask

    task automatic add_row(input int unsigned off, input logic [31:0] word, input logic rd_we,
                           input logic [4:0] rd, input logic [31:0] value);
        core_ctrl_pkg::retire_t exp;
        place_word(off, word);
        exp.pc       = `CORE_RESET_PC + off;
        exp.rd_we    = rd_we;
        exp.rd       = rd;
        exp.rd_value = value;
        expected.push_back(exp);
    endtask

    `include "tb_program.svh"

    task automatic report_mismatch(input string what);
        $display("error at %0t: %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic compare_retire(input core_ctrl_pkg::retire_t got,
                                  input core_ctrl_pkg::retire_t exp);
        logic bad;
        bad = (got.pc !== exp.pc) || (got.rd_we !== exp.rd_we);
        // Rd and its value only mean something when the instruction writes.
        if (exp.rd_we) begin
            bad = bad || (got.rd !== exp.rd) || (got.rd_value !== exp.rd_value);
        end
        if (bad) begin
            report_mismatch({"retire ", retire_text(got), ", expected ", retire_text(exp)});
        end
    endtask

    task automatic compare_pc(input string name, input logic [`CORE_XLEN-1:0] got,
                              input logic [`CORE_XLEN-1:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_halt(input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("halted %b, expected %b", got, exp));
        end
    endtask

    task automatic compare_valid(input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("retire_valid %b, expected %b", got, exp));
        end
    endtask

    initial begin
        wait (table_ready);
        #(watchdog_cycles * clk_period);
        $display("Timeout: the core did not reach ebreak within %0d cycles.", watchdog_cycles);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [11:0]            imm;
        core_ctrl_pkg::retire_t last;
        logic [`CORE_XLEN-1:0]  target;
        rst_n       <= 1'b0;
        prog_we     <= 1'b0;
        prog_addr   <= '0;
        prog_data   <= '0;
        table_ready = 1'b0;
        image_len   = 0;
        void'($urandom(32'hc69cd9c3));

        // Program head fills x28 to x31 with random values.
        for (int k = 0; k < head_words; k++) begin
            imm = 12'($urandom());
            add_row(4 * k, i_word(op_imm, 3'd0, 5'(28 + k), 5'd0, imm), 1'b1, 5'(28 + k),
                    {{20{imm[11]}}, imm});
        end
        build_program();
        watchdog_cycles = image_len + 1 + reset_hold + expected.size() + 16;
        table_ready = 1'b1;

        // Reset stays low through the load and 8 cycles after it.
        for (int i = 0; i < image_len; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= addr_w'(i);
            prog_data <= image[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (reset_hold) @(posedge clk);
        rst_n <= 1'b1;

        foreach (expected[i]) begin
            // The taken path leads to the next retired row, ebreak has none.
            if (i + 1 < expected.size()) begin
                target = expected[i + 1].pc;
            end else begin
                target = expected[i].pc + 32'd4;
            end
            @(negedge clk);
            compare_valid(retire_valid, 1'b1);
            compare_halt(halted, 1'b0);
            compare_pc("pc", pc, expected[i].pc);
            compare_pc("snpc", snpc, expected[i].pc + 32'd4);
            compare_pc("dnpc", dnpc, target);
            compare_retire(retire, expected[i]);
        end

        // The last row is the ebreak, whose pc must hold.
        last = expected[expected.size() - 1];
        repeat (halt_checks) begin
            @(negedge clk);
            compare_halt(halted, 1'b1);
            compare_valid(retire_valid, 1'b0);
            compare_pc("pc", pc, last.pc);
            compare_pc("snpc", snpc, last.pc + 32'd4);
            compare_pc("dnpc", dnpc, last.pc + 32'd4);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* src/rv_core.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module rv_core (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                prog_we,
    input  logic [$clog2(`CORE_IMEM_WORDS)-1:0] prog_addr,
    input  logic [31:0]                         prog_data,
    output logic [`CORE_XLEN-1:0]               pc,
    output logic [`CORE_XLEN-1:0]               snpc,
    output logic [`CORE_XLEN-1:0]               dnpc,
    output core_ctrl_pkg::retire_t              retire,
    output logic                                retire_valid,
    output logic                                halted
);

    rv_isa_pkg::inst_u     inst;
    core_ctrl_pkg::ctrl_t  ctrl;
    core_ctrl_pkg::ctrl_t  ctrl_run;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [4:0]            rd;
    logic [`CORE_XLEN-1:0] rs1_value;
    logic [`CORE_XLEN-1:0] rs2_value;
    logic [`CORE_XLEN-1:0] alu_result;
    logic [`CORE_XLEN-1:0] load_data;
    logic [`CORE_XLEN-1:0] wb_value;
    logic                  br_taken;
    logic                  active;

    // Nothing commits while in reset or after ebreak.
    assign active = rst_n && !halted;

    always_comb begin
        ctrl_run        = ctrl;
        ctrl_run.reg_we = ctrl.reg_we && active;
        ctrl_run.mem_we = ctrl.mem_we && active;
    end

    assign snpc = pc + 32'd4;

    always_comb begin
        if (ctrl.is_jalr) begin
            dnpc = {alu_result[`CORE_XLEN-1:1], 1'b0};
        end else if (ctrl.jump || (ctrl.branch && br_taken)) begin
            dnpc = pc + ctrl.imm;
        end else begin
            dnpc = snpc;
        end
    end

    // Link address, load data or ALU result.
    assign wb_value = ctrl.jump ? snpc : (ctrl.mem_re ? load_data : alu_result);

    // Ebreak holds the pc at its own address.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= `CORE_RESET_PC;
            halted <= 1'b0;
        end else if (!halted) begin
            halted <= ctrl.halt;
            if (!ctrl.halt) begin
                pc <= dnpc;
            end
        end
    end

    always_comb begin
        retire.pc       = pc;
        retire.rd_we    = ctrl_run.reg_we;
        retire.rd       = rd;
        retire.rd_value = wb_value;
    end

    assign retire_valid = active;

    inst_mem u_inst_mem (
        .clk        (clk),
        .prog_we    (prog_we && !rst_n),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .fetch_addr (pc),
        .inst       (inst)
    );

    inst_decoder u_inst_decoder (
        .inst (inst),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .ctrl (ctrl)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .rd_value  (wb_value),
        .we        (ctrl_run.reg_we),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    exec_unit u_exec_unit (
        .ctrl       (ctrl_run),
        .pc         (pc),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .alu_result (alu_result),
        .br_taken   (br_taken)
    );

    data_mem u_data_mem (
        .clk   (clk),
        .ctrl  (ctrl_run),
        .addr  (alu_result),
        .wdata (rs2_value),
        .rdata (load_data)
    );

endmodule

/* src/data_mem.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module data_mem (
    input  logic                    clk,
    input  core_ctrl_pkg::ctrl_t    ctrl,
    input  logic [`CORE_XLEN-1:0]   addr,
    input  logic [`CORE_XLEN-1:0]   wdata,
    output logic [`CORE_XLEN-1:0]   rdata
);

    localparam int unsigned idx_w = $clog2(`CORE_DMEM_WORDS);

    logic [31:0]      mem [`CORE_DMEM_WORDS];
    logic [idx_w-1:0] idx;
    logic [1:0]       lane;
    logic [31:0]      word;
    logic [7:0]       byte_val;
    logic [15:0]      half_val;

    // Upper address bits wrap around the array.
    assign idx  = addr[idx_w+1:2];
    assign lane = addr[1:0];

    always_ff @(posedge clk) begin
        if (ctrl.mem_we) begin
            case (ctrl.mem_size)
                rv_isa_pkg::f3_byte: mem[idx][{lane, 3'b000} +: 8]   <= wdata[7:0];
                rv_isa_pkg::f3_half: mem[idx][{lane[1], 4'b0000} +: 16] <= wdata[15:0];
                default:             mem[idx] <= wdata;
            endcase
        end
    end

    assign word     = mem[idx];
    assign byte_val = word[{lane, 3'b000} +: 8];
    assign half_val = word[{lane[1], 4'b0000} +: 16];

    always_comb begin
        rdata = '0;
        if (ctrl.mem_re) begin
            case (ctrl.mem_size)
                rv_isa_pkg::f3_byte:   rdata = {{24{byte_val[7]}}, byte_val};
                rv_isa_pkg::f3_half:   rdata = {{16{half_val[15]}}, half_val};
                rv_isa_pkg::f3_byte_u: rdata = {24'b0, byte_val};
                rv_isa_pkg::f3_half_u: rdata = {16'b0, half_val};
                default:               rdata = word;
            endcase
        end
    end

endmodule

/* src/exec_unit.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module exec_unit (
    input  core_ctrl_pkg::ctrl_t    ctrl,
    input  logic [`CORE_XLEN-1:0]   pc,
    input  logic [`CORE_XLEN-1:0]   rs1_value,
    input  logic [`CORE_XLEN-1:0]   rs2_value,
    output logic [`CORE_XLEN-1:0]   alu_result,
    output logic                    br_taken
);

    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [4:0]            shamt;

    always_comb begin
        case (ctrl.a_sel)
            core_ctrl_pkg::a_pc:   op_a = pc;
            core_ctrl_pkg::a_zero: op_a = '0;
            default:               op_a = rs1_value;
        endcase
    end

    assign op_b  = (ctrl.b_sel == core_ctrl_pkg::b_imm) ? ctrl.imm : rs2_value;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            core_ctrl_pkg::alu_sub:    alu_result = op_a - op_b;
            core_ctrl_pkg::alu_sll:    alu_result = op_a << shamt;
            core_ctrl_pkg::alu_slt:    alu_result = {{(`CORE_XLEN-1){1'b0}},
                                                     $signed(op_a) < $signed(op_b)};
            core_ctrl_pkg::alu_sltu:   alu_result = {{(`CORE_XLEN-1){1'b0}}, op_a < op_b};
            core_ctrl_pkg::alu_xor:    alu_result = op_a ^ op_b;
            core_ctrl_pkg::alu_srl:    alu_result = op_a >> shamt;
            core_ctrl_pkg::alu_sra:    alu_result = $unsigned($signed(op_a) >>> shamt);
            core_ctrl_pkg::alu_or:     alu_result = op_a | op_b;
            core_ctrl_pkg::alu_and:    alu_result = op_a & op_b;
            core_ctrl_pkg::alu_pass_b: alu_result = op_b;
            default:                   alu_result = op_a + op_b;
        endcase
    end

    // Branch compare always works on the two register values.
    always_comb begin
        br_taken = 1'b0;
        if (ctrl.branch) begin
            case (ctrl.br_cond)
                rv_isa_pkg::f3_beq:  br_taken = (rs1_value == rs2_value);
                rv_isa_pkg::f3_bne:  br_taken = (rs1_value != rs2_value);
                rv_isa_pkg::f3_blt:  br_taken = ($signed(rs1_value) < $signed(rs2_value));
                rv_isa_pkg::f3_bge:  br_taken = ($signed(rs1_value) >= $signed(rs2_value));
                rv_isa_pkg::f3_bltu: br_taken = (rs1_value < rs2_value);
                rv_isa_pkg::f3_bgeu: br_taken = (rs1_value >= rs2_value);
                default:             br_taken = 1'b0;
            endcase
        end
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              rd,
    input  logic [`CORE_XLEN-1:0]   rd_value,
    input  logic                    we,
    output logic [`CORE_XLEN-1:0]   rs1_value,
    output logic [`CORE_XLEN-1:0]   rs2_value
);

    logic [`CORE_XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= rd_value;
        end
    end

    // x0 always reads as zero.
    assign rs1_value = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* src/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  rv_isa_pkg::inst_u     inst,
    output logic [4:0]            rs1,
    output logic [4:0]            rs2,
    output logic [4:0]            rd,
    output core_ctrl_pkg::ctrl_t  ctrl
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        alt;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    function automatic core_ctrl_pkg::alu_op_e alu_fn(input logic [2:0] f3, input logic alt_op);
        core_ctrl_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt_op ? core_ctrl_pkg::alu_sub : core_ctrl_pkg::alu_add;
            3'b001:  op = core_ctrl_pkg::alu_sll;
            3'b010:  op = core_ctrl_pkg::alu_slt;
            3'b011:  op = core_ctrl_pkg::alu_sltu;
            3'b100:  op = core_ctrl_pkg::alu_xor;
            3'b101:  op = alt_op ? core_ctrl_pkg::alu_sra : core_ctrl_pkg::alu_srl;
            3'b110:  op = core_ctrl_pkg::alu_or;
            default: op = core_ctrl_pkg::alu_and;
        endcase
        return op;
    endfunction

    assign opcode = inst.r_fmt.opcode;
    assign funct3 = inst.r_fmt.funct3;
    assign alt    = inst.r_fmt.funct7[5];
    assign rs1    = inst.r_fmt.rs1;
    assign rs2    = inst.r_fmt.rs2;
    assign rd     = inst.r_fmt.rd;

    assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
    assign imm_b = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                    inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {inst.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                    inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        // Anything not listed below is a no-op.
        ctrl          = '0;
        ctrl.mem_size = funct3;
        ctrl.br_cond  = funct3;
        case (opcode)
            rv_isa_pkg::opc_op: begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = alu_fn(funct3, alt);
            end
            rv_isa_pkg::opc_op_imm: begin
                // Only srai uses the alternate encoding here.
                ctrl.reg_we = 1'b1;
                ctrl.b_sel  = core_ctrl_pkg::b_imm;
                ctrl.imm    = imm_i;
                ctrl.alu_op = alu_fn(funct3, alt && (funct3 == 3'b101));
            end
            rv_isa_pkg::opc_load: begin
                ctrl.reg_we = 1'b1;
                ctrl.mem_re = 1'b1;
                ctrl.b_sel  = core_ctrl_pkg::b_imm;
                ctrl.imm    = imm_i;
            end
            rv_isa_pkg::opc_store: begin
                ctrl.mem_we = 1'b1;
                ctrl.b_sel  = core_ctrl_pkg::b_imm;
                ctrl.imm    = imm_s;
            end
            rv_isa_pkg::opc_branch: begin
                ctrl.branch = 1'b1;
                ctrl.imm    = imm_b;
            end
            rv_isa_pkg::opc_jal: begin
                ctrl.reg_we = 1'b1;
                ctrl.jump   = 1'b1;
                ctrl.a_sel  = core_ctrl_pkg::a_pc;
                ctrl.b_sel  = core_ctrl_pkg::b_imm;
                ctrl.imm    = imm_j;
            end
            rv_isa_pkg::opc_jalr: begin
                ctrl.reg_we  = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.is_jalr = 1'b1;
                ctrl.b_sel   = core_ctrl_pkg::b_imm;
                ctrl.imm     = imm_i;
            end
            rv_isa_pkg::opc_lui: begin
                ctrl.reg_we = 1'b1;
                ctrl.a_sel  = core_ctrl_pkg::a_zero;
                ctrl.b_sel  = core_ctrl_pkg::b_imm;
                ctrl.alu_op = core_ctrl_pkg::alu_pass_b;
                ctrl.imm    = imm_u;
            end
            rv_isa_pkg::opc_auipc: begin
                ctrl.reg_we = 1'b1;
                ctrl.a_sel  = core_ctrl_pkg::a_pc;
                ctrl.b_sel  = core_ctrl_pkg::b_imm;
                ctrl.imm    = imm_u;
            end
            rv_isa_pkg::opc_system: begin
                ctrl.halt = (inst == rv_isa_pkg::ebreak_word);
            end
            default: ;
        endcase
    end

endmodule

/* src/inst_mem.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module inst_mem (
    input  logic                                   clk,
    input  logic                                   prog_we,
    input  logic [$clog2(`CORE_IMEM_WORDS)-1:0]    prog_addr,
    input  logic [31:0]                            prog_data,
    input  logic [31:0]                            fetch_addr,
    output rv_isa_pkg::inst_u                      inst
);

    localparam int unsigned idx_w = $clog2(`CORE_IMEM_WORDS);

    logic [31:0] mem [`CORE_IMEM_WORDS];
    logic [31:0] offset;

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Fetch relative to the reset pc, ebreak outside the array.
    assign offset = fetch_addr - `CORE_RESET_PC;

    always_comb begin
        if (offset[31:2] < `CORE_IMEM_WORDS) begin
            inst = mem[offset[idx_w+1:2]];
        end else begin
            inst = rv_isa_pkg::ebreak_word;
        end
    end

endmodule

/* src/core_ctrl_pkg.sv */
package core_ctrl_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        a_rs1,
        a_pc,
        a_zero
    } a_sel_e;

    typedef enum logic {
        b_rs2,
        b_imm
    } b_sel_e;

    // Decoded controls for the instruction in flight.
    typedef struct packed {
        alu_op_e     alu_op;
        a_sel_e      a_sel;
        b_sel_e      b_sel;
        logic        reg_we;
        logic        mem_re;
        logic        mem_we;
        logic [2:0]  mem_size;
        logic        branch;
        logic [2:0]  br_cond;
        logic        jump;
        logic        is_jalr;
        logic        halt;
        logic [31:0] imm;
    } ctrl_t;

    // What the instruction completing this cycle did.
    typedef struct packed {
        logic [31:0] pc;
        logic        rd_we;
        logic [4:0]  rd;
        logic [31:0] rd_value;
    } retire_t;

endpackage

/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

    // Major opcodes of the RV32I base set.
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_system = 7'b1110011
    } opcode_e;

    // Access sizes, shared by loads and stores.
    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    // Branch conditions.
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [31:0] ebreak_word = 32'h0010_0073;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, seen through each encoding format.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

endpackage

/* src/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// First fetch address after reset.
`define CORE_RESET_PC 32'h8000_0000

// Memory depths in 32-bit words.
`define CORE_IMEM_WORDS 256
`define CORE_DMEM_WORDS 256

// Register and data path width.
`define CORE_XLEN 32

`endif
